//--- rtl/axi_lite_pkg.sv
package axi_lite_pkg;

    ////////////////////
    // Response codes
    ////////////////////

    // Two-bit BRESP/RRESP encoding
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    ////////////////////
    // Write response result
    ////////////////////

    // Judged B beat, returned from the result stage to the execute stage
    typedef struct packed {
        logic      ok;
        axi_resp_t resp;
    } bresp_result_t;

endpackage

//--- rtl/dma_reg_pkg.sv
package dma_reg_pkg;

    ////////////////////
    // Data types
    ////////////////////

    typedef logic [31:0] reg_data_t;
    typedef logic [3:0]  reg_strb_t;
    typedef logic [6:0]  reg_offset_t;

    // Every register write is a full word
    localparam reg_strb_t REG_STRB_ALL = 4'hf;

    ////////////////////
    // Register map
    ////////////////////

    // MM2S channel
    localparam reg_offset_t MM2S_DMACR_OFFSET  = 7'h00;
    localparam reg_offset_t MM2S_SA_OFFSET     = 7'h18;
    localparam reg_offset_t MM2S_LENGTH_OFFSET = 7'h28;

    // S2MM channel
    localparam reg_offset_t S2MM_DMACR_OFFSET  = 7'h30;
    localparam reg_offset_t S2MM_DA_OFFSET     = 7'h48;
    localparam reg_offset_t S2MM_LENGTH_OFFSET = 7'h58;

    // Control words written first in each sequence
    localparam reg_data_t MM2S_DMACR_VALUE = 32'h0000_7001;
    localparam reg_data_t S2MM_DMACR_VALUE = 32'h0000_0080;

    ////////////////////
    // Command structs
    ////////////////////

    typedef enum logic {
        DIR_MM2S,
        DIR_S2MM
    } dma_dir_e;

    // Captured channel set-up, held stable while cmd_req is high
    typedef struct packed {
        dma_dir_e  dir;
        reg_data_t buf_addr;
        reg_data_t buf_len;
    } dma_cmd_t;

    // Outcome of one sequence, resp is the code of the failing write
    typedef struct packed {
        logic                  ok;
        axi_lite_pkg::axi_resp_t resp;
    } cmd_status_t;

endpackage

//--- rtl/dma_cmd_decode.sv
`timescale 1ns/1ps

module dma_cmd_decode (
    input  logic                     m_axi_aclk,
    input  logic                     m_axi_aresetn,

    input  logic                     mm2s_en,
    input  dma_reg_pkg::reg_data_t   mm2s_addr,
    input  dma_reg_pkg::reg_data_t   mm2s_len,
    input  logic                     s2mm_en,
    input  dma_reg_pkg::reg_data_t   s2mm_addr,
    input  dma_reg_pkg::reg_data_t   s2mm_len,

    output logic                     cmd_req,
    output dma_reg_pkg::dma_cmd_t    cmd,
    input  logic                     cmd_ack,
    input  dma_reg_pkg::cmd_status_t cmd_status,

    output logic                     busy,
    output logic                     error
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DONE
    } state_e;

    state_e state;

    ////////////////////
    // Command capture
    ////////////////////

    // MM2S wins when both enables are high on the same edge
    always_ff @(posedge m_axi_aclk) begin
        if (state == IDLE) begin
            if (mm2s_en) begin
                cmd.dir      <= dma_reg_pkg::DIR_MM2S;
                cmd.buf_addr <= mm2s_addr;
                cmd.buf_len  <= mm2s_len;
            end else if (s2mm_en) begin
                cmd.dir      <= dma_reg_pkg::DIR_S2MM;
                cmd.buf_addr <= s2mm_addr;
                cmd.buf_len  <= s2mm_len;
            end
        end
    end

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            state   <= IDLE;
            cmd_req <= 1'b0;
            busy    <= 1'b0;
            error   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // cmd_ack is already low here, a new request is allowed
                    if (mm2s_en || s2mm_en) begin
                        cmd_req <= 1'b1;
                        busy    <= 1'b1;
                        error   <= 1'b0;
                        state   <= REQ;
                    end
                end
                REQ: begin
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        error   <= !cmd_status.ok;
                        state   <= DONE;
                    end
                end
                DONE: begin
                    // Wait for execute to finish the return phase
                    if (!cmd_ack) begin
                        busy  <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/dma_reg_write_execute.sv
`timescale 1ns/1ps

module dma_reg_write_execute #(
    parameter int ADDR_WIDTH = 7
) (
    input  logic                        m_axi_aclk,
    input  logic                        m_axi_aresetn,

    input  logic                        cmd_req,
    input  dma_reg_pkg::dma_cmd_t       cmd,
    output logic                        cmd_ack,
    output dma_reg_pkg::cmd_status_t    cmd_status,

    output logic [ADDR_WIDTH-1:0]       awaddr,
    output logic                        awvalid,
    input  logic                        awready,

    output dma_reg_pkg::reg_data_t      wdata,
    output dma_reg_pkg::reg_strb_t      wstrb,
    output logic                        wvalid,
    output logic                        wlast,
    input  logic                        wready,

    output logic                        resp_req,
    input  logic                        resp_ack,
    input  axi_lite_pkg::bresp_result_t resp
);

    typedef enum logic [1:0] {
        STEP_CTRL,
        STEP_ADDR,
        STEP_LEN
    } step_e;

    typedef enum logic [1:0] {
        IDLE,
        ADDR_DATA,
        WAIT_RESP,
        ACK
    } phase_e;

    step_e                    step;
    phase_e                   phase;
    dma_reg_pkg::reg_offset_t wr_offset;
    dma_reg_pkg::reg_data_t   wr_data;
    logic                     aw_done;
    logic                     w_done;

    ////////////////////
    // Write select
    ////////////////////

    // Offset and data follow step and direction, both stable during a beat
    always_comb begin
        wr_offset = '0;
        wr_data   = '0;
        case (step)
            STEP_CTRL: begin
                if (cmd.dir == dma_reg_pkg::DIR_MM2S) begin
                    wr_offset = dma_reg_pkg::MM2S_DMACR_OFFSET;
                    wr_data   = dma_reg_pkg::MM2S_DMACR_VALUE;
                end else begin
                    wr_offset = dma_reg_pkg::S2MM_DMACR_OFFSET;
                    wr_data   = dma_reg_pkg::S2MM_DMACR_VALUE;
                end
            end
            STEP_ADDR: begin
                wr_offset = (cmd.dir == dma_reg_pkg::DIR_MM2S) ?
                            dma_reg_pkg::MM2S_SA_OFFSET : dma_reg_pkg::S2MM_DA_OFFSET;
                wr_data   = cmd.buf_addr;
            end
            STEP_LEN: begin
                wr_offset = (cmd.dir == dma_reg_pkg::DIR_MM2S) ?
                            dma_reg_pkg::MM2S_LENGTH_OFFSET : dma_reg_pkg::S2MM_LENGTH_OFFSET;
                wr_data   = cmd.buf_len;
            end
            default: begin
                wr_offset = '0;
            end
        endcase
    end

    assign awaddr = ADDR_WIDTH'(wr_offset);
    assign wdata  = wr_data;
    assign wstrb  = dma_reg_pkg::REG_STRB_ALL;
    // Single beat writes, so every W beat is the last one
    assign wlast  = wvalid;

    // AW and W finish on their own, in either order
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    ////////////////////
    // Sequence FSM
    ////////////////////

    always_ff @(posedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            phase    <= IDLE;
            step     <= STEP_CTRL;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            resp_req <= 1'b0;
            cmd_ack  <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    if (cmd_req) begin
                        step    <= STEP_CTRL;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        phase   <= ADDR_DATA;
                    end
                end
                ADDR_DATA: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    // Previous response return must be closed first
                    if (aw_done && w_done && !resp_ack) begin
                        resp_req <= 1'b1;
                        phase    <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (resp_ack) begin
                        resp_req <= 1'b0;
                        if (!resp.ok || step == STEP_LEN) begin
                            cmd_ack <= 1'b1;
                            phase   <= ACK;
                        end else begin
                            step    <= (step == STEP_CTRL) ? STEP_ADDR : STEP_LEN;
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            phase   <= ADDR_DATA;
                        end
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        phase   <= IDLE;
                    end
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    // Last judged response becomes the sequence status
    always_ff @(posedge m_axi_aclk) begin
        if (phase == WAIT_RESP && resp_ack) begin
            cmd_status.ok   <= resp.ok;
            cmd_status.resp <= resp.resp;
        end
    end

endmodule

//--- rtl/bresp_result.sv
`timescale 1ns/1ps

module bresp_result (
    input  logic                        m_axi_aclk,
    input  logic                        m_axi_aresetn,

    input  logic                        resp_req,
    output logic                        resp_ack,
    output axi_lite_pkg::bresp_result_t resp,

    input  axi_lite_pkg::axi_resp_t     bresp,
    input  logic                        bvalid,
    output logic                        bready
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_B,
        ACK
    } state_e;

    state_e                  state;
    axi_lite_pkg::axi_resp_t bresp_q;

    ////////////////////
    // B channel FSM
    ////////////////////

    always_ff @(posedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            state    <= IDLE;
            bready   <= 1'b0;
            resp_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (resp_req) begin
                        bready <= 1'b1;
                        state  <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    // bready is high here, so bvalid alone completes the beat
                    if (bvalid) begin
                        bready   <= 1'b0;
                        resp_ack <= 1'b1;
                        state    <= ACK;
                    end
                end
                ACK: begin
                    if (!resp_req) begin
                        resp_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge m_axi_aclk) begin
        if (bvalid && bready) begin
            bresp_q <= bresp;
        end
    end

    // Held while resp_ack is high since bresp_q only loads on a B beat
    assign resp.ok   = (bresp_q == axi_lite_pkg::AXI_RESP_OKAY);
    assign resp.resp = bresp_q;

endmodule

//--- rtl/dma_cfg_master.sv
`timescale 1ns/1ps

module dma_cfg_master #(
    parameter int ADDR_WIDTH = 7
) (
    input  logic                    m_axi_aclk,
    input  logic                    m_axi_aresetn,

    ////////////////////
    // Command inputs
    ////////////////////
    input  logic                    mm2s_en,
    input  dma_reg_pkg::reg_data_t  mm2s_addr,
    input  dma_reg_pkg::reg_data_t  mm2s_len,
    input  logic                    s2mm_en,
    input  dma_reg_pkg::reg_data_t  s2mm_addr,
    input  dma_reg_pkg::reg_data_t  s2mm_len,

    ////////////////////
    // AXI4-Lite write
    ////////////////////
    output logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
    output logic                    m_axi_awvalid,
    input  logic                    m_axi_awready,

    output dma_reg_pkg::reg_data_t  m_axi_wdata,
    output dma_reg_pkg::reg_strb_t  m_axi_wstrb,
    output logic                    m_axi_wvalid,
    output logic                    m_axi_wlast,
    input  logic                    m_axi_wready,

    input  axi_lite_pkg::axi_resp_t m_axi_bresp,
    input  logic                    m_axi_bvalid,
    output logic                    m_axi_bready,

    // Status
    output logic                    dram_controller_busy,
    output logic                    dram_controller_error
);

    // Decode to execute
    logic                        cmd_req;
    dma_reg_pkg::dma_cmd_t       cmd;
    logic                        cmd_ack;
    dma_reg_pkg::cmd_status_t    cmd_status;

    // Execute to result
    logic                        resp_req;
    logic                        resp_ack;
    axi_lite_pkg::bresp_result_t resp;

    dma_cmd_decode u_decode (
        .m_axi_aclk    (m_axi_aclk),
        .m_axi_aresetn (m_axi_aresetn),
        .mm2s_en       (mm2s_en),
        .mm2s_addr     (mm2s_addr),
        .mm2s_len      (mm2s_len),
        .s2mm_en       (s2mm_en),
        .s2mm_addr     (s2mm_addr),
        .s2mm_len      (s2mm_len),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .cmd_status    (cmd_status),
        .busy          (dram_controller_busy),
        .error         (dram_controller_error)
    );

    dma_reg_write_execute #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_execute (
        .m_axi_aclk    (m_axi_aclk),
        .m_axi_aresetn (m_axi_aresetn),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .cmd_status    (cmd_status),
        .awaddr        (m_axi_awaddr),
        .awvalid       (m_axi_awvalid),
        .awready       (m_axi_awready),
        .wdata         (m_axi_wdata),
        .wstrb         (m_axi_wstrb),
        .wvalid        (m_axi_wvalid),
        .wlast         (m_axi_wlast),
        .wready        (m_axi_wready),
        .resp_req      (resp_req),
        .resp_ack      (resp_ack),
        .resp          (resp)
    );

    bresp_result u_result (
        .m_axi_aclk    (m_axi_aclk),
        .m_axi_aresetn (m_axi_aresetn),
        .resp_req      (resp_req),
        .resp_ack      (resp_ack),
        .resp          (resp),
        .bresp         (m_axi_bresp),
        .bvalid        (m_axi_bvalid),
        .bready        (m_axi_bready)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // Starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

//--- verification/dma_cfg_master_assert.sv
`timescale 1ns/1ps

module dma_cfg_master_assert #(
    parameter int ADDR_WIDTH = 7
) (
    input logic                   m_axi_aclk,
    input logic                   m_axi_aresetn,
    input logic [ADDR_WIDTH-1:0]  m_axi_awaddr,
    input logic                   m_axi_awvalid,
    input logic                   m_axi_awready,
    input dma_reg_pkg::reg_data_t m_axi_wdata,
    input logic                   m_axi_wvalid,
    input logic                   m_axi_wready,
    input logic                   m_axi_bvalid,
    input logic                   m_axi_bready,
    input logic                   dram_controller_busy,
    input logic                   dram_controller_error
);

    int unsigned error_count = 0;
    logic        aw_outstanding;

    // Set by an AW beat, cleared by the B beat of the same write
    always_ff @(posedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            aw_outstanding <= 1'b0;
        end else if (m_axi_awvalid && m_axi_awready) begin
            aw_outstanding <= 1'b1;
        end else if (m_axi_bvalid && m_axi_bready) begin
            aw_outstanding <= 1'b0;
        end
    end

    ////////////////////
    // Channel stability
    ////////////////////

    aw_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
        $error("awvalid dropped or awaddr changed before awready");
        error_count++;
    end

    w_hold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else begin
        $error("wvalid dropped or wdata changed before wready");
        error_count++;
    end

    // One write in flight at a time
    single_aw: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
        aw_outstanding |-> !m_axi_awvalid)
    else begin
        $error("second AW issued before the B beat of the previous write");
        error_count++;
    end

    b_once: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
        m_axi_bvalid && m_axi_bready |=> !m_axi_bready)
    else begin
        $error("bready still high after the B beat");
        error_count++;
    end

    busy_cover: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
        (m_axi_awvalid || m_axi_wvalid || m_axi_bready) |-> dram_controller_busy)
    else begin
        $error("bus activity while busy is low");
        error_count++;
    end

    ////////////////////
    // Reset values
    ////////////////////

    reset_low: assert property (@(posedge m_axi_aclk)
        !m_axi_aresetn |=> !m_axi_awvalid && !m_axi_wvalid && !m_axi_bready
                           && !dram_controller_busy && !dram_controller_error)
    else begin
        $error("an output is not low after reset");
        error_count++;
    end

endmodule

bind dma_cfg_master dma_cfg_master_assert #(
    .ADDR_WIDTH (ADDR_WIDTH)
) u_assert (
    .m_axi_aclk            (m_axi_aclk),
    .m_axi_aresetn         (m_axi_aresetn),
    .m_axi_awaddr          (m_axi_awaddr),
    .m_axi_awvalid         (m_axi_awvalid),
    .m_axi_awready         (m_axi_awready),
    .m_axi_wdata           (m_axi_wdata),
    .m_axi_wvalid          (m_axi_wvalid),
    .m_axi_wready          (m_axi_wready),
    .m_axi_bvalid          (m_axi_bvalid),
    .m_axi_bready          (m_axi_bready),
    .dram_controller_busy  (dram_controller_busy),
    .dram_controller_error (dram_controller_error)
);

//--- verification/tb_dma_cfg_master.sv
`timescale 1ns/1ps

module tb_dma_cfg_master;

    localparam int          ADDR_WIDTH       = 7;
    // Up to eight sequences of about 60 cycles each, four times over, plus reset
    localparam int          NUM_SEQUENCES    = 8;
    localparam int          WORST_SEQ_CYCLES = 60;
    localparam int          TIMEOUT_CYCLES   = NUM_SEQUENCES * WORST_SEQ_CYCLES * 4 + 80;
    localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;

    logic                  m_axi_aclk;
    logic                  m_axi_aresetn;
    logic                  mm2s_en;
    logic [31:0]           mm2s_addr;
    logic [31:0]           mm2s_len;
    logic                  s2mm_en;
    logic [31:0]           s2mm_addr;
    logic [31:0]           s2mm_len;
    logic [ADDR_WIDTH-1:0] m_axi_awaddr;
    logic                  m_axi_awvalid;
    logic                  m_axi_awready;
    logic [31:0]           m_axi_wdata;
    logic [3:0]            m_axi_wstrb;
    logic                  m_axi_wvalid;
    logic                  m_axi_wlast;
    logic                  m_axi_wready;
    logic [1:0]            m_axi_bresp;
    logic                  m_axi_bvalid;
    logic                  m_axi_bready;
    logic                  dram_controller_busy;
    logic                  dram_controller_error;

    logic [31:0] lfsr_state = 32'h48ac_81ea;
    logic [31:0] addr_tab [NUM_SEQUENCES];
    logic [31:0] len_tab [NUM_SEQUENCES];
    logic [31:0] aw_log [$];
    logic [31:0] w_log [$];
    logic        aw_armed = 1'b0;
    logic        w_armed = 1'b0;
    logic        b_armed = 1'b0;
    logic        b_fire = 1'b0;
    int          aw_delay = 0;
    int          w_delay = 0;
    int          b_delay = 0;
    int          b_count = 0;
    int          slverr_index = -1;
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clk(m_axi_aclk));

    dma_cfg_master #(.ADDR_WIDTH(ADDR_WIDTH)) u_dut (.*);

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Counts down a 0 to 3 cycle stall, true once it has run out
    function automatic logic stall_done(inout logic armed, inout int delay);
        if (!armed) begin
            delay = int'(draw_bits(2));
            armed = 1'b1;
        end
        if (delay == 0) begin
            armed = 1'b0;
            return 1'b1;
        end
        delay--;
        return 1'b0;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                      name, got, exp));
    endtask

    // Writes from index first on, against one channel's register sequence
    task automatic check_writes(input int first, input int count, input logic to_s2mm,
                                input int idx);
        logic [31:0] exp_addr [3];
        logic [31:0] exp_data [3];
        if (to_s2mm) begin
            exp_addr = '{32'h30, 32'h48, 32'h58};
            exp_data = '{32'h80, ~addr_tab[idx], ~len_tab[idx]};
        end else begin
            exp_addr = '{32'h00, 32'h18, 32'h28};
            exp_data = '{32'h7001, addr_tab[idx], len_tab[idx]};
        end
        check_value("number of AW beats", aw_log.size(), first + count);
        check_value("number of W beats", w_log.size(), first + count);
        for (int i = 0; i < count; i++) begin
            check_value("m_axi_awaddr", aw_log[first + i], exp_addr[i]);
            check_value("m_axi_wdata", w_log[first + i], exp_data[i]);
        end
    endtask

    // One-cycle enable, then busy must be up and error cleared
    task automatic start_command(input logic mm2s, input logic s2mm, input int idx,
                                 input logic hold_s2mm);
        @(negedge m_axi_aclk);
        mm2s_en   = mm2s;
        s2mm_en   = s2mm;
        mm2s_addr = addr_tab[idx];
        mm2s_len  = len_tab[idx];
        s2mm_addr = ~addr_tab[idx];
        s2mm_len  = ~len_tab[idx];
        @(negedge m_axi_aclk);
        mm2s_en = 1'b0;
        s2mm_en = hold_s2mm;
        check_value("dram_controller_busy", dram_controller_busy, 1);
        check_value("dram_controller_error", dram_controller_error, 0);
    endtask

    task automatic wait_idle();
        while (dram_controller_busy) begin
            @(negedge m_axi_aclk);
        end
    endtask

    ////////////////////
    // AXI slave model
    ////////////////////

    always @(negedge m_axi_aclk) begin
        if (!m_axi_aresetn) begin
            m_axi_awready = 1'b0;
            m_axi_wready  = 1'b0;
            m_axi_bvalid  = 1'b0;
            b_fire        = 1'b0;
        end else begin
            // B before AW and W, so a response waits for beats taken on earlier edges
            if (b_fire) begin
                m_axi_bvalid = 1'b0;
                m_axi_bresp  = 2'b00;
                b_fire       = 1'b0;
                b_count++;
            end else begin
                if (!m_axi_bvalid && b_count < aw_log.size() && b_count < w_log.size()
                    && stall_done(b_armed, b_delay)) begin
                    m_axi_bvalid = 1'b1;
                    m_axi_bresp  = (b_count == slverr_index) ? 2'b10 : 2'b00;
                end
                b_fire = m_axi_bvalid && m_axi_bready;
            end
            if (m_axi_awready) begin
                m_axi_awready = 1'b0;
            end else if (m_axi_awvalid && stall_done(aw_armed, aw_delay)) begin
                m_axi_awready = 1'b1;
                aw_log.push_back(32'(m_axi_awaddr));
            end
            if (m_axi_wready) begin
                m_axi_wready = 1'b0;
            end else if (m_axi_wvalid && stall_done(w_armed, w_delay)) begin
                m_axi_wready = 1'b1;
                w_log.push_back(m_axi_wdata);
                check_value("m_axi_wstrb", m_axi_wstrb, 32'hf);
                check_value("m_axi_wlast", m_axi_wlast, 1);
            end
        end
    end

    always @(posedge m_axi_aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout: the sequences did not finish within the cycle limit");
        end
    end

    always @(negedge m_axi_aclk) begin
        if (u_dut.u_assert.error_count != 0) begin
            report_failure("A protocol assertion of the bound checker failed");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        m_axi_aresetn = 1'b0;
        mm2s_en       = 1'b0;
        mm2s_addr     = '0;
        mm2s_len      = '0;
        s2mm_en       = 1'b0;
        s2mm_addr     = '0;
        s2mm_len      = '0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bresp   = 2'b00;
        m_axi_bvalid  = 1'b0;
        for (int i = 0; i < NUM_SEQUENCES; i++) begin
            addr_tab[i] = draw_bits(32);
            len_tab[i]  = draw_bits(32);
        end
        repeat (3) @(negedge m_axi_aclk);
        m_axi_aresetn = 1'b1;

        // Single MM2S, then single S2MM
        start_command(1'b1, 1'b0, 0, 1'b0);
        wait_idle();
        check_writes(0, 3, 1'b0, 0);
        start_command(1'b0, 1'b1, 1, 1'b0);
        wait_idle();
        check_writes(3, 3, 1'b1, 1);

        // Both enables together, S2MM left pending
        start_command(1'b1, 1'b1, 2, 1'b1);
        wait_idle();
        check_writes(6, 3, 1'b0, 2);
        @(negedge m_axi_aclk);
        check_value("dram_controller_busy", dram_controller_busy, 1);
        s2mm_en = 1'b0;
        wait_idle();
        check_writes(9, 3, 1'b1, 2);

        // SLVERR on the address write of the next sequence
        slverr_index = 13;
        start_command(1'b1, 1'b0, 3, 1'b0);
        wait_idle();
        // Give a late length write time to show up
        repeat (4) @(negedge m_axi_aclk);
        check_writes(12, 2, 1'b0, 3);
        check_value("dram_controller_error", dram_controller_error, 1);
        check_value("dram_controller_busy", dram_controller_busy, 0);
        slverr_index = -1;
        start_command(1'b0, 1'b1, 4, 1'b0);
        wait_idle();
        check_writes(14, 3, 1'b1, 4);

        // Enable pulsed mid-sequence is dropped
        start_command(1'b1, 1'b0, 5, 1'b0);
        repeat (2) @(negedge m_axi_aclk);
        s2mm_en = 1'b1;
        @(negedge m_axi_aclk);
        s2mm_en = 1'b0;
        wait_idle();
        repeat (4) @(negedge m_axi_aclk);
        check_value("dram_controller_busy", dram_controller_busy, 0);
        check_writes(17, 3, 1'b0, 5);
        check_value("number of B beats", b_count, 20);

        if (u_dut.u_assert.error_count != 0) begin
            report_failure("A protocol assertion of the bound checker failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- dma_cfg_master.f
rtl/axi_lite_pkg.sv
rtl/dma_reg_pkg.sv
rtl/dma_cmd_decode.sv
rtl/dma_reg_write_execute.sv
rtl/bresp_result.sv
rtl/dma_cfg_master.sv
verification/tb_clock_gen.sv
verification/dma_cfg_master_assert.sv
verification/tb_dma_cfg_master.sv
